// ==== design/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  localparam int ADDR_W = 3;
  localparam int READ_W = 8;
  localparam int HDR_W  = 1 + ADDR_W;       // rw bit plus address
  localparam int CMD_W  = HDR_W + READ_W;

  // One 12-bit command word, read two ways by the lane
  typedef union packed {
    // Write frame, all 12 bits go out on mosi
    struct packed {
      logic              rw;                // 1 = write
      logic [ADDR_W-1:0] addr;
      logic [READ_W-1:0] wdata;
    } wr;
    // Read frame, low byte is the miso window
    struct packed {
      logic              rw;                // 0 = read
      logic [ADDR_W-1:0] addr;
      logic [READ_W-1:0] turn;              // Refilled from miso during the frame
    } rd;
  } spi_cmd_t;

endpackage

`default_nettype wire

// ==== design/spi_cmd_dispatch.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_cmd_dispatch #(
  parameter int N_LANES    = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             cmd_vld,
  input  logic [spi_pkg::CMD_W-1:0]                        cmd_in,
  input  logic [((N_LANES > 1) ? $clog2(N_LANES) : 1)-1:0] cmd_lane,
  input  logic [N_LANES-1:0]                               lane_busy,
  output logic                                             cmd_credit,
  output logic [N_LANES-1:0]                               lane_start,
  output logic [spi_pkg::CMD_W-1:0]                        lane_cmd
);

  localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;
  localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

  logic [spi_pkg::CMD_W-1:0] mem_cmd [FIFO_DEPTH];
  logic [LANE_W-1:0]         mem_lane [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [LANE_W-1:0] head_lane;
  logic push;
  logic pop;

  assign push      = cmd_vld;
  assign head_lane = mem_lane[rd_ptr];
  assign lane_cmd  = mem_cmd[rd_ptr];

  // Head only leaves when its own lane is idle, so later entries wait behind it
  assign pop        = (fill != '0) && !lane_busy[head_lane];
  assign cmd_credit = pop;

  always_comb
  begin
    lane_start = '0;
    if (pop)
    begin
      lane_start[head_lane] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_cmd[wr_ptr]  <= cmd_in;
      mem_lane[wr_ptr] <= cmd_lane;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (push)
      begin
        // Wrap by compare so any depth works
        if (wr_ptr == PTR_W'(FIFO_DEPTH - 1))
          wr_ptr <= '0;
        else
          wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        if (rd_ptr == PTR_W'(FIFO_DEPTH - 1))
          rd_ptr <= '0;
        else
          rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;      // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/spi_lane.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_lane #(
  parameter int CLK_DIV = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  logic [spi_pkg::CMD_W-1:0]  cmd,
  input  logic                       miso,
  input  logic                       take,
  output logic                       busy,
  output logic                       sclk,
  output logic                       cs_n,
  output logic                       mosi,
  output logic                       rd_pending,
  output logic [spi_pkg::READ_W-1:0] rd_data
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  localparam logic [2:0] IDLE   = 3'd0;
  localparam logic [2:0] SETUP  = 3'd1;   // First low half, msb already on mosi
  localparam logic [2:0] SHIFT  = 3'd2;
  localparam logic [2:0] FINISH = 3'd3;   // Low half before cs_n rises
  localparam logic [2:0] HOLD   = 3'd4;   // Read result waits for the collector

  localparam logic [3:0] LAST_BIT = 4'(spi_pkg::CMD_W - 1);

  logic [2:0]                state;
  logic [DIV_W-1:0]          div_cnt;
  logic [3:0]                bit_cnt;
  spi_pkg::spi_cmd_t         cmd_q;
  logic [spi_pkg::CMD_W-1:0] tx_word;
  logic                      half_end;
  logic                      is_read;
  logic                      rise;
  logic                      sample;

  assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));
  assign is_read  = !cmd_q.rd.rw;

  // Rising sclk edge, taken from the register about to go high
  assign rise   = half_end && ((state == SETUP) || ((state == SHIFT) && !sclk));
  assign sample = rise && is_read && (bit_cnt >= spi_pkg::HDR_W);

  // Reads drive only the header, then zeros through the miso window
  always_comb
  begin
    if (is_read)
      tx_word = {cmd_q.rd.rw, cmd_q.rd.addr, {spi_pkg::READ_W{1'b0}}};
    else
      tx_word = {cmd_q.wr.rw, cmd_q.wr.addr, cmd_q.wr.wdata};
  end

  assign busy       = (state != IDLE);
  assign rd_pending = (state == HOLD);
  assign rd_data    = cmd_q.rd.turn;

  // Latched word, the low byte doubles as the read shift register
  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && start)
    begin
      cmd_q <= cmd;
    end
    else if (sample)
    begin
      cmd_q.rd.turn <= {cmd_q.rd.turn[spi_pkg::READ_W-2:0], miso};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (start)
          begin
            state   <= SETUP;
            cs_n    <= 1'b0;
            mosi    <= cmd[spi_pkg::CMD_W-1];   // rw bit, same in both views
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end

        SETUP:
        begin
          if (half_end)
          begin
            state   <= SHIFT;
            sclk    <= 1'b1;
            div_cnt <= '0;
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        SHIFT:
        begin
          if (half_end)
          begin
            div_cnt <= '0;
            sclk    <= !sclk;
            if (sclk)
            begin
              // Falling edge, move mosi or close the frame
              if (bit_cnt == LAST_BIT)
              begin
                state <= FINISH;
                mosi  <= 1'b0;
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
                mosi    <= tx_word[spi_pkg::CMD_W - 2 - bit_cnt];
              end
            end
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        FINISH:
        begin
          if (half_end)
          begin
            cs_n    <= 1'b1;
            div_cnt <= '0;
            if (is_read)
              state <= HOLD;
            else
              state <= IDLE;    // Writes free the lane right away
          end
          else
          begin
            div_cnt <= div_cnt + 1'b1;
          end
        end

        HOLD:
        begin
          if (take)
          begin
            state <= IDLE;
          end
        end

        default:
        begin
          state <= IDLE;
          sclk  <= 1'b0;
          cs_n  <= 1'b1;
          mosi  <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/spi_read_collect.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_read_collect #(
  parameter int N_LANES = 4
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [N_LANES-1:0]                               rd_pending,
  input  logic [N_LANES*spi_pkg::READ_W-1:0]               rd_data,
  output logic [N_LANES-1:0]                               take,
  output logic                                             read_vld,
  output logic [spi_pkg::READ_W-1:0]                       read_data,
  output logic [((N_LANES > 1) ? $clog2(N_LANES) : 1)-1:0] read_lane
);

  localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

  logic [LANE_W-1:0] ptr;       // Lane with first claim this cycle
  logic [LANE_W-1:0] win;
  logic              found;

  // Scan from the pointer and wrap
  always_comb
  begin
    int idx;
    found = 1'b0;
    win   = ptr;
    for (int k = 0; k < N_LANES; k++)
    begin
      idx = (int'(ptr) + k) % N_LANES;
      if (!found && rd_pending[idx])
      begin
        found = 1'b1;
        win   = LANE_W'(idx);
      end
    end
  end

  always_comb
  begin
    take = '0;
    if (found)
    begin
      take[win] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (found)
    begin
      read_data <= rd_data[win*spi_pkg::READ_W +: spi_pkg::READ_W];
      read_lane <= win;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld <= 1'b0;
      ptr      <= '0;
    end
    else
    begin
      read_vld <= found;
      if (found)
      begin
        // Winner goes to the back of the line
        if (win == LANE_W'(N_LANES - 1))
          ptr <= '0;
        else
          ptr <= win + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/spi_multi_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_multi_top #(
  parameter int N_LANES    = 4,
  parameter int FIFO_DEPTH = 4,
  parameter int CLK_DIV    = 2
) (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             cmd_vld,
  input  logic [spi_pkg::CMD_W-1:0]                        cmd_in,
  input  logic [((N_LANES > 1) ? $clog2(N_LANES) : 1)-1:0] cmd_lane,
  input  logic [N_LANES-1:0]                               miso,
  output logic                                             cmd_credit,
  output logic [N_LANES-1:0]                               sclk,
  output logic [N_LANES-1:0]                               cs_n,
  output logic [N_LANES-1:0]                               mosi,
  output logic                                             read_vld,
  output logic [spi_pkg::READ_W-1:0]                       read_data,
  output logic [((N_LANES > 1) ? $clog2(N_LANES) : 1)-1:0] read_lane
);

  logic [N_LANES-1:0]                 lane_busy;
  logic [N_LANES-1:0]                 lane_start;
  logic [spi_pkg::CMD_W-1:0]          lane_cmd;     // Shared, qualified by lane_start
  logic [N_LANES-1:0]                 rd_pending;
  logic [N_LANES*spi_pkg::READ_W-1:0] rd_data;
  logic [N_LANES-1:0]                 take;

  spi_cmd_dispatch #(
    .N_LANES    (N_LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) spi_cmd_dispatch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_in     (cmd_in),
    .cmd_lane   (cmd_lane),
    .lane_busy  (lane_busy),
    .cmd_credit (cmd_credit),
    .lane_start (lane_start),
    .lane_cmd   (lane_cmd)
  );

  for (genvar i = 0; i < N_LANES; i++)
  begin : g_lane
    spi_lane #(
      .CLK_DIV (CLK_DIV)
    ) spi_lane_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (lane_start[i]),
      .cmd        (lane_cmd),
      .miso       (miso[i]),
      .take       (take[i]),
      .busy       (lane_busy[i]),
      .sclk       (sclk[i]),
      .cs_n       (cs_n[i]),
      .mosi       (mosi[i]),
      .rd_pending (rd_pending[i]),
      .rd_data    (rd_data[i*spi_pkg::READ_W +: spi_pkg::READ_W])
    );
  end

  spi_read_collect #(
    .N_LANES (N_LANES)
  ) spi_read_collect_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_pending (rd_pending),
    .rd_data    (rd_data),
    .take       (take),
    .read_vld   (read_vld),
    .read_data  (read_data),
    .read_lane  (read_lane)
  );

endmodule

`default_nettype wire

// ==== dv/spi_multi_props.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_multi_props #(
  parameter int N_LANES    = 4,
  parameter int FIFO_DEPTH = 4
) (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            cmd_vld,
  input logic                            cmd_credit,
  input logic [N_LANES-1:0]              lane_start,
  input logic [N_LANES-1:0]              lane_busy,
  input logic [N_LANES-1:0]              cs_n,
  input logic [N_LANES-1:0]              take,
  input logic                            read_vld,
  input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_fill
);

  int fail_count = 0;

  task automatic record_failure(input string what);
    fail_count++;
    $error("Assertion failed, %s", what);
  endtask

  start_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lane_start))
    else record_failure("more than one lane started in one cycle");

  // Push into a full FIFO is only legal when the head leaves the same cycle
  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_vld && !cmd_credit && (fifo_fill == FIFO_DEPTH)))
    else record_failure("command pushed into a full FIFO");

  idle_cs_high: assert property (@(posedge clk) disable iff (!rst_n) (~lane_busy & ~cs_n) == '0)
    else record_failure("cs_n low on a lane that is not busy");

  // Back-to-back results must come from two different held lanes
  single_serve: assert property (@(posedge clk) disable iff (!rst_n)
    (read_vld && $past(read_vld)) |-> ($past(take, 2) != $past(take)))
    else record_failure("one lane result served twice in a row");

endmodule

bind spi_multi_top spi_multi_props #(.N_LANES(N_LANES), .FIFO_DEPTH(FIFO_DEPTH))
  spi_multi_props_i (.*, .fifo_fill(spi_cmd_dispatch_i.fill));

`default_nettype wire

// ==== dv/spi_slave_model.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_slave_model #(
  parameter int LANE = 0
) (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0]  regs [8];
  logic [11:0] shift_in;
  logic [2:0]  rd_addr;
  logic        rd_op;
  int          cnt;

  initial
  begin
    for (int a = 0; a < 8; a++)
      regs[a] = 8'(LANE * 16 + a);
    miso  = 1'b0;
    rd_op = 1'b0;
    cnt   = 0;
  end

  always @(negedge cs_n)
  begin
    cnt   = 0;
    rd_op = 1'b0;
  end

  // Mode 0, mosi sampled on the rising edge
  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      shift_in = {shift_in[10:0], mosi};
      cnt++;
      if (cnt == 4)
      begin
        rd_op   = !shift_in[3];
        rd_addr = shift_in[2:0];
      end
      if ((cnt == 12) && shift_in[11])
        regs[shift_in[10:8]] = shift_in[7:0];
    end
  end

  // Read byte goes out MSB first once the header is in
  always @(negedge sclk)
  begin
    if (!cs_n && rd_op && (cnt >= 4) && (cnt < 12))
      miso <= regs[rd_addr][11 - cnt];
  end

endmodule

`default_nettype wire

// ==== dv/spi_checker.sv ====
`default_nettype none
`timescale 1ns/10ps

module spi_checker #(
  parameter int N_LANES    = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_vld,
  input  logic [spi_pkg::CMD_W-1:0]   cmd_in,
  input  logic [$clog2(N_LANES)-1:0]  cmd_lane,
  input  logic                        cmd_credit,
  input  logic [N_LANES-1:0]          cs_n,
  input  logic [N_LANES-1:0]          sclk,
  input  logic                        read_vld,
  input  logic [spi_pkg::READ_W-1:0]  read_data,
  input  logic [$clog2(N_LANES)-1:0]  read_lane,
  input  logic                        end_check,
  input  int                          host_credits,
  output int                          error_count,
  output int                          outstanding
);

  logic [7:0] regs [N_LANES][8];
  logic       written [N_LANES][8];
  logic [8:0] pred [N_LANES][256];     // Bit 8 set when the register was written
  logic [7:0] wr_idx [N_LANES];
  logic [7:0] rd_idx [N_LANES];
  logic [8:0] exp;
  logic       seen_cmd = 1'b0;
  int         n_cmds = 0;
  int         n_credits = 0;
  int         n_reads = 0;
  int         n_results = 0;

  initial
  begin
    error_count = 0;
    outstanding = 0;
    for (int l = 0; l < N_LANES; l++)
    begin
      wr_idx[l] = '0;
      rd_idx[l] = '0;
      for (int a = 0; a < 8; a++)
      begin
        regs[l][a]    = 8'(l * 16 + a);
        written[l][a] = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (!seen_cmd && (cmd_credit || read_vld || (cs_n !== '1) || (sclk !== '0)))
      begin
        error_count++;
        $display("Outputs left their idle state before the first command");
      end
      if (cmd_vld)
      begin
        seen_cmd = 1'b1;
        n_cmds++;
        if (cmd_in[11])
        begin
          regs[cmd_lane][cmd_in[10:8]]    = cmd_in[7:0];
          written[cmd_lane][cmd_in[10:8]] = 1'b1;
        end
        else
        begin
          pred[cmd_lane][wr_idx[cmd_lane]] =
            {written[cmd_lane][cmd_in[10:8]], regs[cmd_lane][cmd_in[10:8]]};
          wr_idx[cmd_lane]++;
          outstanding++;
          n_reads++;
        end
      end
      n_credits += int'(cmd_credit);
      if (read_vld)
      begin
        n_results++;
        if (wr_idx[read_lane] == rd_idx[read_lane])
        begin
          error_count++;
          $display("Read result tagged lane %0d with no read outstanding there", read_lane);
        end
        else
        begin
          exp = pred[read_lane][rd_idx[read_lane]];
          rd_idx[read_lane]++;
          outstanding--;
          if (read_data !== exp[7:0])
          begin
            error_count++;
            $display("FAILED %s lane %0d: expected %02h, actual %02h",
                     exp[8] ? "read_after_write" : "read_reset_value",
                     read_lane, exp[7:0], read_data);
          end
        end
      end
      if (end_check)
      begin
        if (n_credits != n_cmds)
        begin
          error_count++;
          $display("FAILED credit_count: expected %0d, actual %0d", n_cmds, n_credits);
        end
        if (n_results != n_reads)
        begin
          error_count++;
          $display("FAILED read_count: expected %0d, actual %0d", n_reads, n_results);
        end
        if (host_credits != FIFO_DEPTH)
        begin
          error_count++;
          $display("FAILED host_credits: expected %0d, actual %0d", FIFO_DEPTH, host_credits);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_spi_multi.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_spi_multi;

  localparam int N_LANES      = 4;
  localparam int FIFO_DEPTH   = 4;
  localparam int CLK_DIV      = 2;
  localparam int LANE_W       = $clog2(N_LANES);
  localparam int N_CMDS       = 200;
  localparam int TIMEOUT_NS   = N_CMDS * 12 * 2 * CLK_DIV * 4 * 10 + 20000;
  localparam int FRAME_CYCLES = (2 * spi_pkg::CMD_W + 1) * CLK_DIV + 4;
  localparam int DRAIN_CYCLES = (FIFO_DEPTH + 2) * FRAME_CYCLES;   // Full FIFO behind one frame

  logic                      clk;
  logic                      rst_n;
  logic                      cmd_vld;
  logic [spi_pkg::CMD_W-1:0] cmd_in;
  logic [LANE_W-1:0]         cmd_lane;
  logic [N_LANES-1:0]        miso;
  logic                      cmd_credit;
  logic [N_LANES-1:0]        sclk;
  logic [N_LANES-1:0]        cs_n;
  logic [N_LANES-1:0]        mosi;
  logic                      read_vld;
  logic [spi_pkg::READ_W-1:0] read_data;
  logic [LANE_W-1:0]         read_lane;
  logic                      end_check;
  int                        credits;
  int                        sent;
  int                        drain;
  int                        checker_errors;
  int                        outstanding;
  int                        assert_errors;

  spi_multi_top #(
    .N_LANES    (N_LANES),
    .FIFO_DEPTH (FIFO_DEPTH),
    .CLK_DIV    (CLK_DIV)
  ) spi_multi_top_i (.*);

  for (genvar i = 0; i < N_LANES; i++)
  begin : g_slave
    spi_slave_model #(.LANE(i)) spi_slave_model_i (
      .sclk (sclk[i]),
      .cs_n (cs_n[i]),
      .mosi (mosi[i]),
      .miso (miso[i])
    );
  end

  spi_checker #(.N_LANES(N_LANES), .FIFO_DEPTH(FIFO_DEPTH)) spi_checker_i (
    .*,
    .host_credits (credits),
    .error_count  (checker_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(7));
    rst_n     = 1'b0;
    cmd_vld   = 1'b0;
    cmd_in    = '0;
    cmd_lane  = '0;
    end_check = 1'b0;
    credits   = FIFO_DEPTH;
    sent      = 0;
    drain     = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Issue every command, counting credits as they come back
    while (sent < N_CMDS)
    begin
      @(posedge clk);
      credits = credits + int'(cmd_credit);
      if ((credits > 0) && (($urandom % 4) != 0))
      begin
        cmd_vld  <= 1'b1;
        cmd_in   <= spi_pkg::CMD_W'($urandom);   // Bit 11 gives half reads
        cmd_lane <= LANE_W'($urandom % N_LANES);
        credits  = credits - 1;
        sent++;
      end
      else
        cmd_vld <= 1'b0;
    end
    // Last credits and read results, bounded by the frame time
    while (((credits != FIFO_DEPTH) || (outstanding != 0)) && (drain < DRAIN_CYCLES))
    begin
      @(posedge clk);
      credits = credits + int'(cmd_credit);
      cmd_vld <= 1'b0;
      drain++;
    end
    @(posedge clk);
    end_check <= 1'b1;
    @(posedge clk);
    end_check <= 1'b0;
    @(posedge clk);
    assert_errors = spi_multi_top_i.spi_multi_props_i.fail_count;
    $display("Errors: checker %0d, assertions %0d, commands sent %0d",
             checker_errors, assert_errors, sent);
    if ((checker_errors == 0) && (assert_errors == 0))
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
design/spi_pkg.sv
design/spi_cmd_dispatch.sv
design/spi_lane.sv
design/spi_read_collect.sv
design/spi_multi_top.sv
dv/spi_multi_props.sv
dv/spi_slave_model.sv
dv/spi_checker.sv
dv/tb_spi_multi.sv
